//--- common/adpcma_pkg.sv
// ADPCM-A decoder shared definitions.
// Widths, step-size and index-adjust tables, and saturation limits.
`default_nettype none

package adpcma_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // two codes per byte, high nibble first.
    typedef logic [7:0] adpcm_byte_t;
    // bit 3 sign, bits 2..0 magnitude.
    typedef logic [3:0] adpcm_code_t;
    typedef logic [5:0] step_index_t;
    // {step index, magnitude}.
    typedef logic [8:0] lut_addr_t;
    typedef logic [11:0] increment_t;
    typedef logic signed [11:0] sample_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // table sizes and limits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int STEP_COUNT = 49;
    localparam int STEP_MAX   = 48;
    localparam int LUT_DEPTH  = 392;
    localparam int INC_MAX    = 2047;
    localparam int SAMPLE_MAX = 2047;
    localparam int SAMPLE_MIN = -2048;

    // step sizes, roughly 1.1x per index.
    localparam increment_t STEP_SIZE [0:STEP_COUNT-1] = '{
        12'd16,   12'd17,   12'd19,   12'd21,   12'd23,   12'd25,   12'd28,
        12'd31,   12'd34,   12'd37,   12'd41,   12'd45,   12'd50,   12'd55,
        12'd60,   12'd66,   12'd73,   12'd80,   12'd88,   12'd97,   12'd107,
        12'd118,  12'd130,  12'd143,  12'd157,  12'd173,  12'd190,  12'd209,
        12'd230,  12'd253,  12'd279,  12'd307,  12'd337,  12'd371,  12'd408,
        12'd449,  12'd494,  12'd544,  12'd598,  12'd658,  12'd724,  12'd796,
        12'd876,  12'd963,  12'd1060, 12'd1166, 12'd1282, 12'd1411, 12'd1552
    };

    // step index change per code magnitude.
    localparam logic signed [4:0] INDEX_ADJUST [0:7] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd5, 5'sd7, 5'sd9
    };

endpackage

`default_nettype wire

//--- adpcma/adpcma_nibble.sv
// ADPCM-A nibble sequencer.
// Latches an input byte and issues its two codes, high nibble first.
`timescale 1ns/100ps
`default_nettype none

module adpcma_nibble
    import adpcma_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        cen,
    input  wire adpcm_byte_t data,
    input  wire logic        data_valid,
    output adpcm_code_t      code,
    output logic             code_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_high,
        st_low
    } state_t;

    state_t      state;
    adpcm_byte_t byte_q;

    // sequencer and valid flag.
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            code_valid <= 1'b0;
        end else if (cen) begin
            case (state)
                st_high: begin
                    code_valid <= 1'b1;
                    state      <= st_low;
                end
                st_low: begin
                    code_valid <= 1'b1;
                    // back-to-back bytes skip idle.
                    state      <= data_valid ? st_high : st_idle;
                end
                default: begin
                    code_valid <= 1'b0;
                    state      <= data_valid ? st_high : st_idle;
                end
            endcase
        end
    end

    // byte latch and code mux.
    always_ff @(posedge clk) begin
        if (cen) begin
            if (data_valid && state != st_high) begin
                byte_q <= data;
            end
            code <= (state == st_high) ? byte_q[7:4] : byte_q[3:0];
        end
    end

endmodule

`default_nettype wire

//--- adpcma/adpcma_step.sv
// ADPCM-A step index tracker.
// Forms the increment table address and adapts the step index per code.
`timescale 1ns/100ps
`default_nettype none

module adpcma_step
    import adpcma_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        cen,
    input  wire adpcm_code_t code,
    input  wire logic        code_valid,
    output lut_addr_t        lut_addr,
    output logic             code_sign,
    output logic             addr_valid
);

    step_index_t       step_idx;
    step_index_t       idx_next;
    logic [2:0]        mag;
    logic signed [7:0] idx_sum;

    assign mag     = code[2:0];
    assign idx_sum = $signed({2'b00, step_idx}) + INDEX_ADJUST[mag];

    // clamp to the table range.
    always_comb begin
        if (idx_sum < 0) begin
            idx_next = '0;
        end else if (idx_sum > STEP_MAX) begin
            idx_next = step_index_t'(STEP_MAX);
        end else begin
            idx_next = idx_sum[5:0];
        end
    end

    // control state.
    always_ff @(posedge clk) begin
        if (reset) begin
            step_idx   <= '0;
            addr_valid <= 1'b0;
        end else if (cen) begin
            addr_valid <= code_valid;
            if (code_valid) begin
                step_idx <= idx_next;
            end
        end
    end

    // address uses the index before this code updates it.
    always_ff @(posedge clk) begin
        if (cen && code_valid) begin
            lut_addr  <= {step_idx, mag};
            code_sign <= code[3];
        end
    end

endmodule

`default_nettype wire

//--- adpcma/adpcma_lut.sv
// ADPCM-A increment table.
// 49 step sizes by 8 magnitudes, read through a registered port.
`timescale 1ns/100ps
`default_nettype none

module adpcma_lut
    import adpcma_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      cen,
    input  wire lut_addr_t addr,
    output increment_t     inc
);

    increment_t lut [0:LUT_DEPTH-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // table fill
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // inc = step * (2*mag + 1) / 8, floored and limited.
    initial begin
        int val;
        for (int s = 0; s < STEP_COUNT; s++) begin
            for (int m = 0; m < 8; m++) begin
                val = (int'(STEP_SIZE[s]) * (2 * m + 1)) / 8;
                if (val > INC_MAX) begin
                    val = INC_MAX;
                end
                lut[s * 8 + m] = increment_t'(val);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (cen) begin
            inc <= lut[addr];
        end
    end

endmodule

`default_nettype wire

//--- adpcma/adpcma_accum.sv
// ADPCM-A sample accumulator.
// Adds or subtracts the increment and saturates to 12 bits.
`timescale 1ns/100ps
`default_nettype none

module adpcma_accum
    import adpcma_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       cen,
    input  wire increment_t inc,
    input  wire logic       code_sign,
    input  wire logic       addr_valid,
    output sample_t         sample,
    output logic            sample_valid
);

    logic               sign_q;
    logic               valid_q;
    logic               out_q;
    logic signed [13:0] sum;

    // sign and valid wait one tick for the table read.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (cen) begin
            valid_q <= addr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            sign_q <= code_sign;
        end
    end

    // two guard bits keep the sum exact.
    assign sum = sign_q ? ($signed({{2{sample[11]}}, sample}) - $signed({2'b00, inc}))
                        : ($signed({{2{sample[11]}}, sample}) + $signed({2'b00, inc}));

    always_ff @(posedge clk) begin
        if (reset) begin
            sample <= '0;
            out_q  <= 1'b0;
        end else if (cen) begin
            out_q <= valid_q;
            if (valid_q) begin
                if (sum > SAMPLE_MAX) begin
                    sample <= sample_t'(SAMPLE_MAX);
                end else if (sum < SAMPLE_MIN) begin
                    sample <= sample_t'(SAMPLE_MIN);
                end else begin
                    sample <= sum[11:0];
                end
            end
        end
    end

    // pulse shows only on the tick itself.
    assign sample_valid = out_q & cen;

endmodule

`default_nettype wire

//--- src/adpcma_decoder.sv
// ADPCM-A single-channel decoder top level.
// Byte stream in, 12-bit signed samples out, five ticks of latency.
`timescale 1ns/100ps
`default_nettype none

module adpcma_decoder
    import adpcma_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        cen,
    input  wire adpcm_byte_t data,
    input  wire logic        data_valid,
    output sample_t          sample,
    output logic             sample_valid
);

    adpcm_code_t code;
    logic        code_valid;
    lut_addr_t   lut_addr;
    logic        code_sign;
    logic        addr_valid;
    increment_t  inc;

    // byte to codes.
    adpcma_nibble u_nibble (
        .clk        (clk),
        .reset      (reset),
        .cen        (cen),
        .data       (data),
        .data_valid (data_valid),
        .code       (code),
        .code_valid (code_valid)
    );

    // step adaptation and table address.
    adpcma_step u_step (
        .clk        (clk),
        .reset      (reset),
        .cen        (cen),
        .code       (code),
        .code_valid (code_valid),
        .lut_addr   (lut_addr),
        .code_sign  (code_sign),
        .addr_valid (addr_valid)
    );

    adpcma_lut u_lut (
        .clk  (clk),
        .cen  (cen),
        .addr (lut_addr),
        .inc  (inc)
    );

    // saturating output stage.
    adpcma_accum u_accum (
        .clk          (clk),
        .reset        (reset),
        .cen          (cen),
        .inc          (inc),
        .code_sign    (code_sign),
        .addr_valid   (addr_valid),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

//--- testbench/adpcma_decoder_sva.sv
// ADPCM-A decoder port assertions.
// Bound to the decoder top level; checks the output pulse and the byte spacing.
`timescale 1ns/100ps
`default_nettype none

module adpcma_decoder_sva (
    input wire logic clk,
    input wire logic reset,
    input wire logic cen,
    input wire logic data_valid,
    input wire logic sample_valid
);

    logic byte_last_tick;

    // was the previous tick a byte tick.
    always_ff @(posedge clk) begin
        if (reset) begin
            byte_last_tick <= 1'b0;
        end else if (cen) begin
            byte_last_tick <= data_valid;
        end
    end

    // pulse only on ticks.
    pulse_on_tick: assert property (@(posedge clk) sample_valid |-> cen)
        else $error("sample_valid high while cen is low");

    pulse_low_after_reset: assert property (@(posedge clk) reset |=> !sample_valid)
        else $error("sample_valid high in the cycle after reset");

    // bytes at least two ticks apart.
    byte_spacing: assert property (@(posedge clk) disable iff (reset)
        (cen && byte_last_tick) |-> !data_valid)
        else $error("data_valid on the tick right after a byte tick");

endmodule

bind adpcma_decoder adpcma_decoder_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .cen          (cen),
    .data_valid   (data_valid),
    .sample_valid (sample_valid)
);

`default_nettype wire

//--- testbench/adpcma_decoder_tb.sv
// ADPCM-A decoder testbench.
// Drives byte streams, decodes them in a reference model and checks every sample.
`timescale 1ns/100ps
`default_nettype none

module adpcma_decoder_tb
    import adpcma_pkg::*;
;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test lengths and run limit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int N_IDLE       = 10;
    localparam int N_UP         = 10;
    localparam int N_DOWN       = 30;
    localparam int N_SAT_POS    = 12;
    localparam int N_SAT_NEG    = 12;
    localparam int N_LIMIT      = 8;
    localparam int N_TIMING     = 20;
    localparam int N_CEN        = 60;
    localparam int N_RANDOM     = 320;
    localparam int TOTAL_BYTES  = 1 + N_UP + N_DOWN + N_SAT_POS + N_SAT_NEG + N_LIMIT
                                  + N_TIMING + N_CEN + N_RANDOM;
    localparam int MAX_GAP      = 4;
    localparam int DRAIN_TICKS  = 12;
    localparam int N_DRAINS     = 6;
    localparam int BUDGET_TICKS = N_IDLE + TOTAL_BYTES * MAX_GAP + N_DRAINS * DRAIN_TICKS;
    // random cen roughly halves the tick rate, so allow plenty of cycles.
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * BUDGET_TICKS + 100;
    // pulse follows the T+4 edge and is sampled on the next tick edge.
    localparam int LAT_HIGH = 5;
    localparam int LAT_LOW  = 6;

    logic        clk = 1'b0;
    logic        reset;
    logic        cen;
    adpcm_byte_t data;
    logic        data_valid;
    sample_t     sample;
    logic        sample_valid;

    integer      seed;
    logic        cen_random;
    int          tick_num;
    int          obs_tick;
    int          mismatch_count;
    int          other_errors;
    int          sample_count;
    step_index_t model_idx;
    int          model_acc;
    sample_t     exp_samples[$];
    int          exp_ticks[$];
    sample_t     exp_s;
    int          exp_t;

    adpcma_decoder uut (
        .clk          (clk),
        .reset        (reset),
        .cen          (cen),
        .data         (data),
        .data_valid   (data_valid),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one code against the model state, then adapt the index.
    function automatic sample_t decode_code(input adpcm_code_t c);
        int mag;
        int inc;
        int acc;
        int idx;
        mag = int'(c[2:0]);
        inc = (int'(STEP_SIZE[model_idx]) * (2 * mag + 1)) / 8;
        if (inc > INC_MAX) begin
            inc = INC_MAX;
        end
        acc = c[3] ? model_acc - inc : model_acc + inc;
        if (acc > SAMPLE_MAX) begin
            acc = SAMPLE_MAX;
        end else if (acc < SAMPLE_MIN) begin
            acc = SAMPLE_MIN;
        end
        idx = int'(model_idx) + int'(INDEX_ADJUST[mag]);
        if (idx < 0) begin
            idx = 0;
        end else if (idx > STEP_MAX) begin
            idx = STEP_MAX;
        end
        model_acc = acc;
        model_idx = step_index_t'(idx);
        return sample_t'(acc);
    endfunction

    task automatic check_sample(input string what, input sample_t exp, input sample_t got);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s expected %0d got %0d", $time, what, exp, got);
        end
    endtask

    task automatic check_index(input string what, input step_index_t exp,
                               input step_index_t got);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s expected index %0d got %0d",
                     $time, what, exp, got);
        end
    endtask

    task automatic check_latency(input string what, input int exp, input int got);
        if (got != exp) begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s expected tick %0d got %0d", $time, what, exp, got);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // holds the inputs until a tick takes them.
    task automatic drive_tick(input logic dv, input adpcm_byte_t d);
        logic c;
        c = 1'b0;
        while (!c) begin
            @(posedge clk);
            c = cen_random ? $random(seed) & 1 : 1'b1;
            cen        <= c;
            data       <= d;
            data_valid <= dv;
        end
        tick_num++;
    endtask

    task automatic issue_byte(input adpcm_byte_t b, input int gap);
        sample_t s_hi;
        sample_t s_lo;
        int      byte_tick;
        int      i;
        s_hi      = decode_code(b[7:4]);
        s_lo      = decode_code(b[3:0]);
        byte_tick = tick_num + 1;
        exp_samples.push_back(s_hi);
        exp_ticks.push_back(byte_tick + LAT_HIGH);
        exp_samples.push_back(s_lo);
        exp_ticks.push_back(byte_tick + LAT_LOW);
        drive_tick(1'b1, b);
        for (i = 1; i < gap; i++) begin
            drive_tick(1'b0, 8'h00);
        end
    endtask

    // idle ticks until every expected sample came out.
    task automatic drain_pipeline();
        int n;
        n = 0;
        while (n < DRAIN_TICKS && exp_samples.size() != 0) begin
            drive_tick(1'b0, 8'h00);
            @(negedge clk);
            n++;
        end
        if (exp_samples.size() != 0) begin
            other_errors++;
            $display("%0d expected samples still outstanding after the drain at %0t ns",
                     exp_samples.size(), $time);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare process
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        if (!reset && cen) begin
            obs_tick = obs_tick + 1;
        end
        if (sample_valid) begin
            if (exp_samples.size() == 0) begin
                other_errors++;
                $display("sample_valid seen at %0t ns with no sample expected", $time);
            end else begin
                exp_s = exp_samples.pop_front();
                exp_t = exp_ticks.pop_front();
                check_sample($sformatf("sample %0d", sample_count), exp_s, sample);
                check_latency($sformatf("sample %0d timing", sample_count), exp_t, obs_tick);
                sample_count++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int i;
        int codes;
        int exp_idx;
        reset          = 1'b1;
        cen            = 1'b0;
        data           = 8'h00;
        data_valid     = 1'b0;
        seed           = 56;
        cen_random     = 1'b0;
        tick_num       = 0;
        obs_tick       = 0;
        mismatch_count = 0;
        other_errors   = 0;
        sample_count   = 0;
        model_idx      = '0;
        model_acc      = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // reset state, then the first byte at index 0.
        for (i = 0; i < N_IDLE; i++) begin
            drive_tick(1'b0, 8'h00);
        end
        issue_byte(8'h00, 2);
        check_sample("first code after reset", sample_t'(2), exp_samples[0]);
        check_sample("second code after reset", sample_t'(4), exp_samples[1]);
        drain_pipeline();

        // index climbs by 9 per code and clamps at the top.
        for (i = 0; i < N_UP; i++) begin
            issue_byte(8'h7F, 2);
            codes   = 2 * (i + 1);
            exp_idx = (9 * codes > STEP_MAX) ? STEP_MAX : 9 * codes;
            check_index("index rising", step_index_t'(exp_idx), model_idx);
        end
        // and falls by 1 per code down to 0.
        for (i = 0; i < N_DOWN; i++) begin
            issue_byte(8'h08, 2);
            codes   = 2 * (i + 1);
            exp_idx = (STEP_MAX - codes < 0) ? 0 : STEP_MAX - codes;
            check_index("index falling", step_index_t'(exp_idx), model_idx);
        end
        drain_pipeline();

        // saturation both ways, then the increment limit near full scale.
        for (i = 0; i < N_SAT_POS; i++) begin
            issue_byte(8'h77, 2);
        end
        check_sample("positive saturation", sample_t'(SAMPLE_MAX), sample_t'(model_acc));
        for (i = 0; i < N_SAT_NEG; i++) begin
            issue_byte(8'hFF, 2);
        end
        check_sample("negative saturation", sample_t'(SAMPLE_MIN), sample_t'(model_acc));
        for (i = 0; i < N_LIMIT; i++) begin
            issue_byte(8'h7F, 2);
        end
        drain_pipeline();

        // back-to-back bytes with cen held high.
        for (i = 0; i < N_TIMING; i++) begin
            issue_byte(adpcm_byte_t'($random(seed)), 2);
        end
        drain_pipeline();

        // cen dropped on random cycles.
        cen_random = 1'b1;
        for (i = 0; i < N_CEN; i++) begin
            issue_byte(adpcm_byte_t'($random(seed)), 2 + ($unsigned($random(seed)) % 2));
        end
        drain_pipeline();
        cen_random = 1'b0;

        // long random stream.
        for (i = 0; i < N_RANDOM; i++) begin
            issue_byte(adpcm_byte_t'($random(seed)), 2 + ($unsigned($random(seed)) % 3));
        end
        drain_pipeline();

        @(negedge clk);
        $display("checked %0d samples: %0d mismatches, %0d other errors",
                 sample_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog.
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checked %0d samples: %0d mismatches, %0d other errors",
                 sample_count, mismatch_count, other_errors + 1);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
common/adpcma_pkg.sv
adpcma/adpcma_nibble.sv
adpcma/adpcma_step.sv
adpcma/adpcma_lut.sv
adpcma/adpcma_accum.sv
src/adpcma_decoder.sv
testbench/adpcma_decoder_sva.sv
testbench/adpcma_decoder_tb.sv

//--- Bender.yml
package:
  name: adpcma_decoder

sources:
  - common/adpcma_pkg.sv
  - adpcma/adpcma_nibble.sv
  - adpcma/adpcma_step.sv
  - adpcma/adpcma_lut.sv
  - adpcma/adpcma_accum.sv
  - src/adpcma_decoder.sv
  - target: test
    files:
      - testbench/adpcma_decoder_sva.sv
      - testbench/adpcma_decoder_tb.sv

# testbench top: adpcma_decoder_tb
# design top: adpcma_decoder
